/* exe_config.svh */
// --------------------
// execute stage configuration
// word and register file sizes, L1 instruction cache window
// --------------------
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath
`define XLEN      32                // data and address width
`define NUM_GPR   32                // x0 .. x31
`define GPR_ASZ   5                 // bits of a register address

// L1 I$ address window, both ends inclusive
// a store that lands in here has to invalidate the I$ line
`define L1_IC_LO  32'h0001_0000     // first byte of the I$ window
`define L1_IC_HI  32'h0001_FFFF     // last byte of the I$ window

`endif

/* exe_pkg.sv */
// --------------------
// execute stage types
// decode record, forwarding record, memory stage record
// and the per-unit results
// --------------------
`include "exe_config.svh"

package exe_pkg;

   typedef logic [`XLEN-1:0]      word_t;           // data or address
   typedef logic [`GPR_ASZ-1:0]   gpr_addr_t;
   typedef word_t [`NUM_GPR-1:0]  gpr_file_t;       // gpr[n] holds xn

   typedef enum logic [2:0] {ALU_INSTR, BR_INSTR, LD_INSTR, ST_INSTR, ILL_INSTR} ig_type_e;

   typedef enum logic [3:0] {A_ADD, A_SUB, A_SLL, A_SLT, A_SLTU,
                             A_XOR, A_SRL, A_SRA, A_OR, A_AND} alu_op_e;
   typedef enum logic [3:0] {B_ADD, B_JAL, B_JALR} br_op_e;   // B_ADD is any Bxx

   // op field, decoded by group
   typedef union packed {
      alu_op_e alu_op;                               // ALU_INSTR view
      br_op_e  br_op;                                // BR_INSTR view
   } op_u;

   // operand selects
   typedef enum logic [1:0] {AS_RS1, AS_PC, AS_ZERO, AS_IMM} alu_sel_e;
   localparam alu_sel_e AS_RS2 = AS_RS1;             // y takes rs2 on the register code
   typedef enum logic [1:0] {BS_PC, BS_RS1} br_sel_e;   // target base

   typedef union packed {
      alu_sel_e alu_sel;                             // ALU_INSTR view
      br_sel_e  br_sel;                              // BR_INSTR view
   } sel_u;

   // decode -> execute
   typedef struct packed {
      word_t      pc;
      word_t      imm;                               // sign extended immediate
      logic [2:0] funct3;
      op_u        op;
      sel_u       sel_x;
      sel_u       sel_y;
      gpr_addr_t  rd_addr;
      gpr_addr_t  rs1_addr;
      gpr_addr_t  rs2_addr;
      logic       rd_wr;                             // instr writes rd
      logic       rs1_rd;                            // instr reads rs1
      logic       rs2_rd;                            // instr reads rs2
      ig_type_e   ig_type;
      word_t      predicted_addr;                    // next pc guessed by fetch
   } dec_to_exe_t;

   // one forwarding source (MEM or WB stage)
   typedef struct packed {
      logic       valid;
      logic       rd_wr;
      gpr_addr_t  rd_addr;
      word_t      rd_data;
   } fwd_gpr_t;

   // execute -> memory
   typedef struct packed {
      word_t      pc;
      ig_type_e   ig_type;
      logic       rd_wr;
      gpr_addr_t  rd_addr;
      word_t      rd_data;
      logic       is_ld;
      logic       is_st;
      word_t      ls_addr;
      word_t      st_data;
      logic [1:0] size;                              // log2 bytes, 0 byte 1 half 2 word
      logic       zero_ext;
      logic       inv_flag;                          // store hits the I$ window
      logic       mispre;                            // fetch went the wrong way
      logic       instr_err;                         // misaligned target or access
      word_t      br_pc;                             // faulting target for the trap
   } exe_to_mem_t;

   // unit results
   typedef struct packed {
      word_t      rd_data;
   } alu_res_t;

   typedef struct packed {
      word_t      br_pc;                             // resolved next pc
      word_t      no_br_pc;                          // pc+4, also the link value
      logic       mis;
   } br_res_t;

   typedef struct packed {
      word_t      ls_addr;
      word_t      st_data;
      logic [1:0] size;
      logic       zero_ext;
      logic       mis;
   } ls_res_t;

endpackage

/* operand_forward.sv */
`timescale 1ns/1ns
// --------------------
// operand forwarding
// rs1/rs2 come from MEM forward, WB forward or the register file,
// newest result first
// --------------------
module operand_forward
(
   input  exe_pkg::dec_to_exe_t  d2e_data,
   input  exe_pkg::gpr_file_t    gpr,            // flat register file
   input  exe_pkg::fwd_gpr_t     fwd_mem,        // result leaving MEM
   input  exe_pkg::fwd_gpr_t     fwd_wb,         // result leaving WB
   output exe_pkg::word_t        rs1_val,
   output exe_pkg::word_t        rs2_val
);
   import exe_pkg::*;

   word_t rs1_rf;                                // gpr[rs1_addr]
   word_t rs2_rf;                                // gpr[rs2_addr]

   // a source matches when the operand is read, the source writes a real register
   // and the addresses agree, x0 never forwards
   function automatic logic fwd_hit(input logic src_rd, input gpr_addr_t src_addr,
                                    input fwd_gpr_t fwd);
      return src_rd & fwd.valid & fwd.rd_wr & (fwd.rd_addr == src_addr) &
             (src_addr != '0);
   endfunction

   // MEM is younger than WB so it wins
   function automatic word_t fwd_pick(input logic src_rd, input gpr_addr_t src_addr,
                                      input word_t rf_val, input fwd_gpr_t m,
                                      input fwd_gpr_t w);
      if (fwd_hit(src_rd, src_addr, m))
         return m.rd_data;
      else if (fwd_hit(src_rd, src_addr, w))
         return w.rd_data;
      else
         return rf_val;                          // nothing in flight
   endfunction

   assign rs1_rf  = gpr[d2e_data.rs1_addr];
   assign rs2_rf  = gpr[d2e_data.rs2_addr];

   // --------------------
   assign rs1_val = fwd_pick(d2e_data.rs1_rd, d2e_data.rs1_addr, rs1_rf, fwd_mem, fwd_wb);
   assign rs2_val = fwd_pick(d2e_data.rs2_rd, d2e_data.rs2_addr, rs2_rf, fwd_mem, fwd_wb);

endmodule

/* alu_unit.sv */
`timescale 1ns/1ns
// --------------------
// integer ALU
// x from rs1/pc/zero, y from rs2/imm, one cycle
// --------------------
`include "exe_config.svh"

module alu_unit
(
   input  exe_pkg::dec_to_exe_t  d2e_data,
   input  exe_pkg::word_t        rs1_val,        // forwarded rs1
   input  exe_pkg::word_t        rs2_val,        // forwarded rs2
   output exe_pkg::alu_res_t     res
);
   import exe_pkg::*;

   localparam int SHW = $clog2(`XLEN);          // shift amount width

   word_t          x;                            // first operand
   word_t          y;                            // second operand
   logic [SHW-1:0] shamt;

   always_comb
   begin
      case (d2e_data.sel_x.alu_sel)              // x source
         AS_RS1:  x = rs1_val;
         AS_PC:   x = d2e_data.pc;               // auipc
         AS_ZERO: x = '0;                        // lui
         default: x = rs1_val;
      endcase

      case (d2e_data.sel_y.alu_sel)              // y source
         AS_IMM:  y = d2e_data.imm;
         AS_RS2:  y = rs2_val;
         default: y = rs2_val;
      endcase

      shamt = y[SHW-1:0];                        // only low bits shift

      case (d2e_data.op.alu_op)
         A_ADD:   res.rd_data = x + y;
         A_SUB:   res.rd_data = x - y;
         A_SLL:   res.rd_data = x << shamt;
         A_SLT:   res.rd_data = word_t'($signed(x) < $signed(y));
         A_SLTU:  res.rd_data = word_t'(x < y);
         A_XOR:   res.rd_data = x ^ y;
         A_SRL:   res.rd_data = x >> shamt;
         A_SRA:   res.rd_data = word_t'($signed(x) >>> shamt);   // keeps sign
         A_OR:    res.rd_data = x | y;
         A_AND:   res.rd_data = x & y;
         default: res.rd_data = '0;
      endcase
   end

endmodule

/* branch_unit.sv */
`timescale 1ns/1ns
// --------------------
// branch unit
// Bxx condition, JAL/JALR target, link value
// and target misalignment
// --------------------
`include "exe_config.svh"

module branch_unit
(
   input  exe_pkg::dec_to_exe_t  d2e_data,
   input  exe_pkg::word_t        rs1_val,
   input  exe_pkg::word_t        rs2_val,
   output exe_pkg::br_res_t      res
);
   import exe_pkg::*;

   word_t base;                                  // Bxx target base
   word_t fall;                                  // pc+4
   word_t jalr_sum;
   logic  take;                                  // Bxx condition true

   always_comb
   begin
      case (d2e_data.sel_x.br_sel)
         BS_PC:   base = d2e_data.pc;
         BS_RS1:  base = rs1_val;
         default: base = d2e_data.pc;
      endcase

      fall     = d2e_data.pc + word_t'(4);
      jalr_sum = rs1_val + d2e_data.imm;

      // --------------------
      // condition from funct3
      case (d2e_data.funct3)
         3'b000:  take = (rs1_val == rs2_val);                    // beq
         3'b001:  take = (rs1_val != rs2_val);                    // bne
         3'b100:  take = ($signed(rs1_val) <  $signed(rs2_val));  // blt
         3'b101:  take = ($signed(rs1_val) >= $signed(rs2_val));  // bge
         3'b110:  take = (rs1_val <  rs2_val);                    // bltu
         3'b111:  take = (rs1_val >= rs2_val);                    // bgeu
         default: take = 1'b0;                   // not a branch encoding
      endcase

      // --------------------
      case (d2e_data.op.br_op)
         B_ADD:   res.br_pc = take ? (base + d2e_data.imm) : fall;
         B_JAL:   res.br_pc = d2e_data.pc + d2e_data.imm;
         B_JALR:  res.br_pc = {jalr_sum[`XLEN-1:1], 1'b0};       // lsb dropped
         default: res.br_pc = fall;
      endcase

      res.no_br_pc = fall;                       // link for jal/jalr
      res.mis      = res.br_pc[1];               // IALIGN 32, no C ext
   end

endmodule

/* load_store_unit.sv */
`timescale 1ns/1ns
// --------------------
// load/store address unit
// address, size, zero extend, store data, misalignment
// --------------------
module load_store_unit
(
   input  exe_pkg::dec_to_exe_t  d2e_data,
   input  exe_pkg::word_t        rs1_val,        // base register
   input  exe_pkg::word_t        rs2_val,        // store source
   output exe_pkg::ls_res_t      res
);
   import exe_pkg::*;

   word_t addr;                                  // effective address

   always_comb
   begin
      addr         = rs1_val + d2e_data.imm;

      res.ls_addr  = addr;
      res.st_data  = rs2_val;                    // MEM stage picks the lanes
      res.size     = d2e_data.funct3[1:0];       // 0 byte, 1 half, 2 word
      res.zero_ext = d2e_data.funct3[2];         // lbu / lhu

      // natural alignment per size
      case (d2e_data.funct3[1:0])
         2'd1:    res.mis = addr[0];             // half at odd byte
         2'd2:    res.mis = |addr[1:0];          // word off a 4 byte line
         default: res.mis = 1'b0;                // bytes always fit
      endcase
   end

endmodule

/* result_select.sv */
`timescale 1ns/1ns
// --------------------
// result select
// builds the MEM stage record from the unit outputs
// and raises the fetch reload on a mispredict
// --------------------
`include "exe_config.svh"

module result_select
(
   input  logic                  d2e_valid,
   input  exe_pkg::dec_to_exe_t  d2e_data,
   input  exe_pkg::alu_res_t     alu,
   input  exe_pkg::br_res_t      br,
   input  exe_pkg::ls_res_t      ls,
   output exe_pkg::exe_to_mem_t  exe_out,
   output logic                  rld_pc_flag,    // fetch must reload
   output exe_pkg::word_t        rld_pc_addr
);
   import exe_pkg::*;

   logic rd_wr_ok;                               // rd write, never to x0
   logic in_ic;                                  // address inside the I$ window

   assign rd_wr_ok = d2e_data.rd_wr & (d2e_data.rd_addr != '0);
   assign in_ic    = (ls.ls_addr >= `L1_IC_LO) && (ls.ls_addr <= `L1_IC_HI);

   always_comb
   begin
      exe_out     = '0;                          // idle record is all zero
      rld_pc_flag = 1'b0;
      rld_pc_addr = '0;

      if (d2e_valid)
      begin
         exe_out.pc      = d2e_data.pc;
         exe_out.ig_type = d2e_data.ig_type;

         case (d2e_data.ig_type)
            ALU_INSTR:
            begin
               exe_out.rd_wr   = rd_wr_ok;
               exe_out.rd_addr = d2e_data.rd_addr;
               exe_out.rd_data = alu.rd_data;
            end

            BR_INSTR:
            begin
               if (br.mis)                       // trap taken later in MEM
               begin
                  exe_out.instr_err = 1'b1;
                  exe_out.br_pc     = br.br_pc;
               end
               else if (br.br_pc != d2e_data.predicted_addr)
               begin
                  exe_out.mispre = 1'b1;
                  rld_pc_flag    = 1'b1;         // refetch from the real target
                  rld_pc_addr    = br.br_pc;
               end
               else if (d2e_data.op.br_op inside {B_JAL, B_JALR})
               begin
                  exe_out.rd_wr   = rd_wr_ok;
                  exe_out.rd_addr = d2e_data.rd_addr;
                  exe_out.rd_data = br.no_br_pc; // return address
               end
            end

            LD_INSTR:
            begin
               exe_out.rd_wr     = rd_wr_ok;     // data itself comes from MEM
               exe_out.rd_addr   = d2e_data.rd_addr;
               exe_out.is_ld     = 1'b1;
               exe_out.ls_addr   = ls.ls_addr;
               exe_out.size      = ls.size;
               exe_out.instr_err = ls.mis;
            end

            ST_INSTR:
            begin
               exe_out.is_st     = 1'b1;
               exe_out.ls_addr   = ls.ls_addr;
               exe_out.st_data   = ls.st_data;
               exe_out.size      = ls.size;
               exe_out.zero_ext  = ls.zero_ext;
               exe_out.inv_flag  = in_ic;        // self modifying code
               exe_out.instr_err = ls.mis;
            end

            ILL_INSTR: ;                         // pc and group only, WB traps
            default: ;
         endcase
      end
   end

endmodule

/* stage_pipe.sv */
`timescale 1ns/1ns
// --------------------
// EXE -> MEM pipe register
// one entry with a full flag
// --------------------
module stage_pipe
(
   input  logic                  clk_in,
   input  logic                  reset,
   input  logic                  flush,          // same effect as reset
   input  logic                  write,          // transfer in
   input  logic                  read,           // transfer out
   input  exe_pkg::exe_to_mem_t  data_in,
   output exe_pkg::exe_to_mem_t  data_out,
   output logic                  full
);

   // --------------------
   // occupancy
   always_ff @(posedge clk_in)
   begin
      if (reset | flush)
         full <= 1'b0;
      else if (write)
         full <= 1'b1;                           // also covers read and write together
      else if (read)
         full <= 1'b0;
   end

   // payload, held until the next write
   always_ff @(posedge clk_in)
   begin
      if (write)
         data_out <= data_in;
   end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ns
// --------------------
// RV32I execute stage
// forwarding, ALU / branch / load-store units,
// result select and the pipe register toward MEM
// --------------------
module execute_stage
(
   input  logic                  clk_in,
   input  logic                  reset,
   input  logic                  halt,           // stop taking instructions
   input  logic                  pipe_flush,     // drop what sits in the pipe

   // decode side
   input  logic                  d2e_valid,
   input  exe_pkg::dec_to_exe_t  d2e_data,
   output logic                  d2e_rdy,

   // operand sources
   input  exe_pkg::gpr_file_t    gpr,
   input  exe_pkg::fwd_gpr_t     fwd_mem,
   input  exe_pkg::fwd_gpr_t     fwd_wb,

   // memory side
   output logic                  e2m_valid,
   output exe_pkg::exe_to_mem_t  e2m_data,
   input  logic                  e2m_rdy,

   // fetch reload
   output logic                  rld_pc_flag,
   output exe_pkg::word_t        rld_pc_addr
);
   import exe_pkg::*;

   logic        xfer_in;                         // decode hands over
   logic        xfer_out;                        // MEM takes the record
   logic        pipe_full;

   word_t       rs1_val;
   word_t       rs2_val;
   alu_res_t    alu_res;
   br_res_t     br_res;
   ls_res_t     ls_res;
   exe_to_mem_t exe_out;                         // record before the pipe

   // --------------------
   // handshake
   assign d2e_rdy   = !reset & !halt & (!pipe_full | xfer_out);   // room now or next edge
   assign xfer_in   = d2e_valid & d2e_rdy;
   assign xfer_out  = pipe_full & e2m_rdy;
   assign e2m_valid = pipe_full;

   // --------------------
   operand_forward i_operand_forward (.d2e_data(d2e_data), .gpr(gpr), .fwd_mem(fwd_mem),
                                      .fwd_wb(fwd_wb), .rs1_val(rs1_val), .rs2_val(rs2_val));

   alu_unit        i_alu_unit        (.d2e_data(d2e_data), .rs1_val(rs1_val),
                                      .rs2_val(rs2_val), .res(alu_res));

   branch_unit     i_branch_unit     (.d2e_data(d2e_data), .rs1_val(rs1_val),
                                      .rs2_val(rs2_val), .res(br_res));

   load_store_unit i_load_store_unit (.d2e_data(d2e_data), .rs1_val(rs1_val),
                                      .rs2_val(rs2_val), .res(ls_res));

   result_select   i_result_select   (.d2e_valid(d2e_valid), .d2e_data(d2e_data),
                                      .alu(alu_res), .br(br_res), .ls(ls_res),
                                      .exe_out(exe_out), .rld_pc_flag(rld_pc_flag),
                                      .rld_pc_addr(rld_pc_addr));

   stage_pipe      i_stage_pipe      (.clk_in(clk_in), .reset(reset), .flush(pipe_flush),
                                      .write(xfer_in), .read(xfer_out), .data_in(exe_out),
                                      .data_out(e2m_data), .full(pipe_full));

endmodule

/* tb_execute.sv */
`timescale 1ns/1ns
// --------------------
// execute stage testbench
// directed tests, each record checked against a reference model
// of the stage rules
// --------------------
`include "exe_config.svh"

module tb_execute;
   import exe_pkg::*;

   localparam int MAX_CYCLES = 3000;             // about 6x the length of all tests

   typedef logic [191:0] val_t;                  // wide enough for a whole record

   logic        clk_in;
   logic        reset;
   logic        halt;
   logic        pipe_flush;
   logic        d2e_valid;
   dec_to_exe_t d2e_data;
   logic        d2e_rdy;
   gpr_file_t   gpr;
   fwd_gpr_t    fwd_mem;
   fwd_gpr_t    fwd_wb;
   logic        e2m_valid;
   exe_to_mem_t e2m_data;
   logic        e2m_rdy;
   logic        rld_pc_flag;
   word_t       rld_pc_addr;

   logic [31:0] rng_state;
   int          cycles = 0;

   execute_stage i_execute_stage (.*);

   initial
   begin
      clk_in = 1'b0;
      forever #20 clk_in = ~clk_in;              // 40 ns period
   end

   // run limit
   always @(posedge clk_in)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   // --------------------
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);   // xorshift32
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check(input string name, input val_t got, input val_t exp);
      if (got !== exp)
      begin
         $display("mismatch %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // operand as the stage should see it, MEM before WB before the register file
   function automatic word_t operand(input logic rd, input gpr_addr_t a);
      if (rd && a != '0 && fwd_mem.valid && fwd_mem.rd_wr && fwd_mem.rd_addr == a)
         return fwd_mem.rd_data;
      if (rd && a != '0 && fwd_wb.valid && fwd_wb.rd_wr && fwd_wb.rd_addr == a)
         return fwd_wb.rd_data;
      return gpr[a];
   endfunction

   // --------------------
   // reference model of the record and the fetch reload
   function automatic exe_to_mem_t expect_rec(input dec_to_exe_t d, output logic rl,
                                              output word_t ra);
      exe_to_mem_t e;
      word_t       r1;
      word_t       r2;
      word_t       x;
      word_t       y;
      word_t       tgt;
      word_t       ea;
      logic        take;
      r1        = operand(d.rs1_rd, d.rs1_addr);
      r2        = operand(d.rs2_rd, d.rs2_addr);
      ea        = r1 + d.imm;                    // also the jalr sum
      e         = '0;
      rl        = 1'b0;
      ra        = '0;
      e.pc      = d.pc;
      e.ig_type = d.ig_type;
      case (d.ig_type)
         ALU_INSTR:
         begin
            x = (d.sel_x.alu_sel == AS_PC) ? d.pc : (d.sel_x.alu_sel == AS_ZERO) ? '0 : r1;
            y = (d.sel_y.alu_sel == AS_IMM) ? d.imm : r2;
            case (d.op.alu_op)
               A_ADD:   e.rd_data = x + y;
               A_SUB:   e.rd_data = x - y;
               A_SLL:   e.rd_data = x << y[4:0];
               A_SLT:   e.rd_data = {31'b0, $signed(x) < $signed(y)};
               A_SLTU:  e.rd_data = {31'b0, x < y};
               A_XOR:   e.rd_data = x ^ y;
               A_SRL:   e.rd_data = x >> y[4:0];
               A_SRA:   e.rd_data = $signed(x) >>> y[4:0];
               A_OR:    e.rd_data = x | y;
               A_AND:   e.rd_data = x & y;
               default: e.rd_data = '0;
            endcase
            e.rd_wr   = d.rd_wr && (d.rd_addr != '0);
            e.rd_addr = d.rd_addr;
         end
         BR_INSTR:
         begin
            // funct3[2:1] picks eq / lt / ltu, funct3[0] inverts
            case (d.funct3[2:1])
               2'b00:   take = (r1 == r2);
               2'b10:   take = $signed(r1) < $signed(r2);
               2'b11:   take = r1 < r2;
               default: take = 1'b0;
            endcase
            take = take ^ d.funct3[0];
            case (d.op.br_op)
               B_JAL:   tgt = d.pc + d.imm;
               B_JALR:  tgt = ea & ~32'h1;
               default: tgt = take ? ((d.sel_x.br_sel == BS_RS1) ? r1 : d.pc) + d.imm
                                   : d.pc + 4;
            endcase
            if (tgt[1])
            begin
               e.instr_err = 1'b1;
               e.br_pc     = tgt;
            end
            else if (tgt != d.predicted_addr)
            begin
               e.mispre = 1'b1;
               rl       = 1'b1;
               ra       = tgt;
            end
            else if (d.op.br_op != B_ADD)        // link only on a good jump
            begin
               e.rd_wr   = d.rd_wr && (d.rd_addr != '0);
               e.rd_addr = d.rd_addr;
               e.rd_data = d.pc + 4;
            end
         end
         LD_INSTR, ST_INSTR:
         begin
            e.ls_addr   = ea;
            e.size      = d.funct3[1:0];
            e.instr_err = (e.size == 2'd1 && ea[0]) || (e.size == 2'd2 && ea[1:0] != 2'b00);
            if (d.ig_type == LD_INSTR)
            begin
               e.is_ld   = 1'b1;
               e.rd_wr   = d.rd_wr && (d.rd_addr != '0);
               e.rd_addr = d.rd_addr;
            end
            else
            begin
               e.is_st    = 1'b1;
               e.st_data  = r2;
               e.zero_ext = d.funct3[2];
               e.inv_flag = (ea >= `L1_IC_LO) && (ea <= `L1_IC_HI);
            end
         end
         default: ;                              // illegal, pc and group only
      endcase
      return e;
   endfunction

   // --------------------
   function automatic dec_to_exe_t new_instr(input ig_type_e g);
      dec_to_exe_t d;
      d          = '0;                           // add, rs1/rs2 selects, pc base
      d.pc       = next_rand() & 32'hFFFF_FFFC;
      d.ig_type  = g;
      d.rd_addr  = 5'd1;
      d.rs1_addr = 5'd3;
      d.rs2_addr = 5'd4;
      d.rd_wr    = 1'b1;
      d.rs1_rd   = 1'b1;
      d.rs2_rd   = 1'b1;
      return d;
   endfunction

   task automatic set_gpr(input gpr_addr_t a, input word_t v);
      @(posedge clk_in);
      gpr[a] <= v;
   endtask

   // present one instruction, wait for the transfer in, check the record
   task automatic send(input dec_to_exe_t d);
      exe_to_mem_t exp_rec;
      logic        exp_rld;
      word_t       exp_addr;
      @(posedge clk_in);
      d2e_valid <= 1'b1;
      d2e_data  <= d;
      @(negedge clk_in);
      exp_rec = expect_rec(d, exp_rld, exp_addr);   // inputs settled here
      check("rld_pc_flag", val_t'(rld_pc_flag), val_t'(exp_rld));
      check("rld_pc_addr", val_t'(rld_pc_addr), val_t'(exp_addr));
      while (!d2e_rdy)
         @(negedge clk_in);
      @(posedge clk_in);                         // transfer in on this edge
      d2e_valid <= 1'b0;
      @(negedge clk_in);
      check("e2m_valid", val_t'(e2m_valid), val_t'(1'b1));
      check("e2m_data", val_t'(e2m_data), val_t'(exp_rec));
   endtask

   // --------------------
   task automatic alu_random();
      dec_to_exe_t d;
      logic [31:0] r;
      for (int i = 0; i < 40; i++)
      begin
         d               = new_instr(ALU_INSTR);
         r               = next_rand();
         d.imm           = next_rand();
         d.op.alu_op     = alu_op_e'(i % 10);
         d.sel_x.alu_sel = alu_sel_e'(i % 3);     // rs1, pc, zero
         d.sel_y.alu_sel = (i % 2) ? AS_IMM : AS_RS2;
         d.rd_addr       = (i % 8 == 0) ? 5'd0 : r[4:0];
         d.rs1_addr      = r[9:5];
         d.rs2_addr      = r[14:10];
         send(d);
         if (d.rd_addr == '0)
            check("e2m_data.rd_wr", val_t'(e2m_data.rd_wr), val_t'(1'b0));
      end
   endtask

   // add x1, x(a1), x4 with the given forwards
   task automatic fwd_add(input fwd_gpr_t m, input fwd_gpr_t w, input gpr_addr_t a1,
                          input logic rd1, input word_t exp_sum);
      dec_to_exe_t d;
      @(posedge clk_in);
      fwd_mem <= m;
      fwd_wb  <= w;
      d          = new_instr(ALU_INSTR);
      d.rs1_addr = a1;
      d.rs1_rd   = rd1;
      send(d);
      check("e2m_data.rd_data", val_t'(e2m_data.rd_data), val_t'(exp_sum));
   endtask

   task automatic forward_priority();
      word_t a;
      word_t b;
      a = next_rand();
      b = next_rand();
      fwd_add({2'b11, 5'd3, a}, {2'b11, 5'd3, b}, 5'd3, 1'b1, a + gpr[4]);   // MEM wins
      fwd_add({2'b11, 5'd9, a}, {2'b11, 5'd3, b}, 5'd3, 1'b1, b + gpr[4]);   // WB only
      fwd_add({2'b11, 5'd0, a}, {2'b11, 5'd0, b}, 5'd0, 1'b1, gpr[4]);       // x0
      fwd_add({2'b11, 5'd3, a}, {2'b11, 5'd3, b}, 5'd3, 1'b0, gpr[3] + gpr[4]);
      fwd_add({2'b10, 5'd3, a}, {2'b10, 5'd3, b}, 5'd3, 1'b1, gpr[3] + gpr[4]);
      @(posedge clk_in);
      fwd_mem <= '0;
      fwd_wb  <= '0;
   endtask

   task automatic branch_resolve();
      dec_to_exe_t d;
      for (int p = 0; p < 3; p++)
      begin
         // pairs give each condition both outcomes
         set_gpr(5'd3, (p == 0) ? 32'hFFFF_FFF0 : 32'h10);
         set_gpr(5'd4, (p == 2) ? 32'hFFFF_FFF0 : 32'h10);
         for (int f = 0; f < 8; f++)
            for (int guess = 0; guess < 2; guess++)
            begin
               if (f == 2 || f == 3)
                  continue;                      // not branch encodings
               d                = new_instr(BR_INSTR);
               d.op.br_op       = B_ADD;
               d.funct3         = 3'(f);
               d.imm            = 32'h40;
               d.predicted_addr = guess ? d.pc + 32'h40 : d.pc + 32'h4;
               send(d);
            end
      end
      set_gpr(5'd3, 32'h0000_2000);
      for (int guess = 1; guess >= 0; guess--)   // wrong guess last
      begin
         d                = new_instr(BR_INSTR);
         d.op.br_op       = B_JAL;
         d.imm            = 32'h100;
         d.predicted_addr = guess ? d.pc + 32'h100 : d.pc + 32'h8;
         send(d);
         d                = new_instr(BR_INSTR);
         d.op.br_op       = B_JALR;
         d.imm            = 32'h5;               // bit 0 of the sum is dropped
         d.predicted_addr = guess ? 32'h2004 : 32'h3000;
         send(d);
      end
      @(negedge clk_in);
      check("rld_pc_flag with d2e_valid low", val_t'(rld_pc_flag), val_t'(1'b0));
   endtask

   task automatic misaligned_target();
      dec_to_exe_t d;
      d                = new_instr(BR_INSTR);
      d.op.br_op       = B_JAL;
      d.imm            = 32'h102;
      d.predicted_addr = d.pc + 32'h4;
      send(d);
      d.op.br_op       = B_JALR;
      d.imm            = 32'h7;                  // 0x2006
      send(d);
      d.op.br_op       = B_ADD;
      d.funct3         = 3'd6;                   // bltu 0x2000 < 0xFFFF_FFF0
      d.sel_x.br_sel   = BS_RS1;
      d.imm            = 32'h2;
      send(d);
   endtask

   task automatic load_store_access();
      dec_to_exe_t d;
      set_gpr(5'd3, 32'h0000_4000);
      for (int f = 0; f < 6; f++)
         for (int off = 0; off < 4; off++)
         begin
            if (f == 3)
               continue;
            d        = new_instr(LD_INSTR);
            d.funct3 = 3'(f);
            d.imm    = word_t'(off);
            send(d);
            d.ig_type = ST_INSTR;
            send(d);
         end
      // byte stores on both edges of the I$ window
      set_gpr(5'd3, `L1_IC_LO);
      for (int e = 0; e < 4; e++)
      begin
         if (e == 2)
            set_gpr(5'd3, `L1_IC_HI);
         d     = new_instr(ST_INSTR);
         d.imm = (e == 0) ? 32'hFFFF_FFFF : (e == 3) ? 32'h1 : 32'h0;
         send(d);
         check("e2m_data.inv_flag", val_t'(e2m_data.inv_flag), val_t'(e == 1 || e == 2));
      end
   endtask

   task automatic handshake_stall();
      dec_to_exe_t d;
      dec_to_exe_t d_wait;
      exe_to_mem_t held;
      exe_to_mem_t exp_rec;
      logic        rl;
      word_t       ra;
      @(posedge clk_in);
      e2m_rdy <= 1'b0;                           // MEM stalls
      d = new_instr(ALU_INSTR);
      send(d);
      held   = expect_rec(d, rl, ra);            // record that must sit in the pipe
      d_wait = new_instr(ALU_INSTR);
      @(posedge clk_in);
      d2e_valid <= 1'b1;                         // second instruction waits
      d2e_data  <= d_wait;
      repeat (4)
      begin
         @(negedge clk_in);
         check("d2e_rdy", val_t'(d2e_rdy), val_t'(1'b0));
         check("e2m_data", val_t'(e2m_data), val_t'(held));
      end
      @(posedge clk_in);
      e2m_rdy <= 1'b1;
      @(negedge clk_in);
      check("d2e_rdy", val_t'(d2e_rdy), val_t'(1'b1));
      @(posedge clk_in);                         // out and in on the same edge
      d2e_valid <= 1'b0;
      @(negedge clk_in);
      exp_rec = expect_rec(d_wait, rl, ra);
      check("e2m_valid", val_t'(e2m_valid), val_t'(1'b1));
      check("e2m_data", val_t'(e2m_data), val_t'(exp_rec));
      // --------------------
      @(posedge clk_in);
      halt <= 1'b1;
      @(negedge clk_in);
      check("d2e_rdy", val_t'(d2e_rdy), val_t'(1'b0));
      @(posedge clk_in);
      halt    <= 1'b0;
      e2m_rdy <= 1'b0;
      send(new_instr(ALU_INSTR));
      @(posedge clk_in);
      pipe_flush <= 1'b1;
      @(posedge clk_in);
      pipe_flush <= 1'b0;
      e2m_rdy    <= 1'b1;
      @(negedge clk_in);
      check("e2m_valid", val_t'(e2m_valid), val_t'(1'b0));
      d        = new_instr(ILL_INSTR);           // junk fields must not leak
      d.imm    = next_rand();
      d.funct3 = 3'd5;
      send(d);
   endtask

   // --------------------
   initial
   begin
      rng_state  = 32'h3a2e6392;
      reset      = 1'b1;
      halt       = 1'b0;
      pipe_flush = 1'b0;
      d2e_valid  = 1'b0;
      d2e_data   = '0;
      e2m_rdy    = 1'b1;
      fwd_mem    = '0;
      fwd_wb     = '0;
      for (int r = 0; r < `NUM_GPR; r++)
         gpr[gpr_addr_t'(r)] = (r == 0) ? '0 : next_rand();
      repeat (8) @(posedge clk_in);
      @(negedge clk_in);
      check("e2m_valid", val_t'(e2m_valid), val_t'(1'b0));
      check("d2e_rdy", val_t'(d2e_rdy), val_t'(1'b0));
      repeat (8) @(posedge clk_in);              // 16 cycles of reset
      reset <= 1'b0;
      alu_random();
      forward_priority();
      branch_resolve();
      misaligned_target();
      load_store_access();
      handshake_stall();
      $display("Done: no errors");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+.
exe_pkg.sv
operand_forward.sv
alu_unit.sv
branch_unit.sv
load_store_unit.sv
result_select.sv
stage_pipe.sv
execute_stage.sv
tb_execute.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_execute -f filelist.f

out=$(./obj_dir/Vtb_execute || true)
echo "$out"
if grep -q "Done: no errors" <<< "$out"; then
   exit 0
fi
echo "simulation failed"
exit 1
